// ==== tb.f ====
+incdir+verilog
verilog/devtlb_pkg.sv
verilog/devtlb_gen_ram.sv
verilog/devtlb_lookup.sv
verilog/devtlb_top.sv
testbench/devtlb_tb.sv

// ==== testbench/devtlb_patterns.txt ====
# Columns: F vpn ppn perm | L vpn hit ppn perm | I | W idle_cycles
# All values are hex except the W cycle count, which is decimal
L 00001 0 00000 0
L 12345 0 00000 0
W 2
# Fill then back-to-back lookups
F 00010 aaaaa 3
F 00020 bbbbb 2
W 1
L 00010 1 aaaaa 3
L 00020 1 bbbbb 2
L 00010 1 aaaaa 3
L 00030 0 00000 0
W 1
# Refill of a present page, in place
F 00010 ccccc 1
W 1
L 00010 1 ccccc 1
L 00020 1 bbbbb 2
W 1
# Sixteen fills into an empty TLB, then one that evicts entry 0
I
F 01000 20000 0
F 01001 20001 1
F 01002 20002 2
F 01003 20003 3
F 01004 20004 0
F 01005 20005 1
F 01006 20006 2
F 01007 20007 3
F 01008 20008 0
F 01009 20009 1
F 0100a 2000a 2
F 0100b 2000b 3
F 0100c 2000c 0
F 0100d 2000d 1
F 0100e 2000e 2
F 0100f 2000f 3
W 1
F 01010 30010 2
W 1
L 01000 0 00000 0
L 01001 1 20001 1
L 01002 1 20002 2
L 01003 1 20003 3
L 01004 1 20004 0
L 01005 1 20005 1
L 01006 1 20006 2
L 01007 1 20007 3
L 01008 1 20008 0
L 01009 1 20009 1
L 0100a 1 2000a 2
L 0100b 1 2000b 3
L 0100c 1 2000c 0
L 0100d 1 2000d 1
L 0100e 1 2000e 2
L 0100f 1 2000f 3
L 01010 1 30010 2
W 1
# Invalidate everything, then a single fill
I
W 1
L 01001 0 00000 0
L 01010 0 00000 0
F 05000 abcde 1
W 1
L 05000 1 abcde 1
L 01005 0 00000 0

// ==== testbench/devtlb_tb.sv ====
// Device TLB testbench driven by operations and expected responses from a pattern file
// Must run from the project root so the pattern path resolves
// Responses are sampled on the falling edge and must arrive exactly two cycles
// after the lookup was driven

`timescale 1ns/1ps

`include "devtlb_settings.svh"

module devtlb_tb;

    import devtlb_pkg::*;

    localparam int DRAIN_LIMIT = 20;
    localparam int MAX_OPS     = 1000;

    // Expected response and the cycle it is due in
    typedef struct packed {
        logic [31:0] due;
        devtlb_rsp_t rsp;
    } exp_t;

    logic         gramclk;
    logic         rst;
    logic         req_valid;
    devtlb_req_t  req;
    logic         fill_valid;
    devtlb_fill_t fill;
    logic         inv_all;
    logic         rsp_valid;
    devtlb_rsp_t  rsp;

    logic [31:0]  cycle;
    int           errors;
    int           checked;
    exp_t         exp_q[$];

    devtlb_top i_devtlb_top (
        .gramclk    (gramclk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .fill_valid (fill_valid),
        .fill       (fill),
        .inv_all    (inv_all),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

    always #50 gramclk = ~gramclk;

    always @(posedge gramclk) begin
        cycle <= cycle + 1;
    end

    // Next edge, then all strobes back to idle
    task automatic step_cycle();
        @(posedge gramclk);
        #10;
        req_valid  = 1'b0;
        fill_valid = 1'b0;
        inv_all    = 1'b0;
    endtask

    task automatic check_rsp(input devtlb_rsp_t want);
        checked++;
        assert (rsp.hit == want.hit) else begin
            errors++;
            $display("[ERROR] %0t rsp.hit: got %0h, expected %0h", $time, rsp.hit, want.hit);
        end
        assert (rsp.ppn == want.ppn) else begin
            errors++;
            $display("[ERROR] %0t rsp.ppn: got %0h, expected %0h", $time, rsp.ppn, want.ppn);
        end
        assert (rsp.perm == want.perm) else begin
            errors++;
            $display("[ERROR] %0t rsp.perm: got %0h, expected %0h", $time, rsp.perm, want.perm);
        end
    endtask

    // ------------------------------------------------------------------------
    // Response checker
    // ------------------------------------------------------------------------

    always @(negedge gramclk) begin : check_stage
        exp_t front;
        if (!rst) begin
            if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
                front = exp_q.pop_front();
                assert (rsp_valid) else begin
                    errors++;
                    $display("No response strobe at %0t, two cycles after a lookup", $time);
                end
                if (rsp_valid) begin
                    check_rsp(front.rsp);
                end
            end else begin
                assert (!rsp_valid) else begin
                    errors++;
                    $display("Response strobe at %0t with no lookup due", $time);
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus from the pattern file
    // ------------------------------------------------------------------------

    initial begin : stimulus
        int                        fd;
        int                        code;
        int                        ops;
        int                        count;
        int                        wait_cycles;
        logic [7:0]                op;
        logic [8*100-1:0]          skip_line;
        logic                      hit;
        logic [`DEVTLB_VPN_W-1:0]  vpn;
        logic [`DEVTLB_PPN_W-1:0]  ppn;
        logic [`DEVTLB_PERM_W-1:0] perm;
        exp_t                      next;

        gramclk    = 1'b0;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        fill_valid = 1'b0;
        fill       = '0;
        inv_all    = 1'b0;
        cycle      = '0;
        errors     = 0;
        checked    = 0;

        repeat (5) @(posedge gramclk);
        #10;
        rst = 1'b0;

        fd = $fopen("testbench/devtlb_patterns.txt", "r");
        assert (fd != 0) else begin
            errors++;
            $display("Cannot open the pattern file testbench/devtlb_patterns.txt");
        end

        ops = 0;
        while (fd != 0 && ops < MAX_OPS && $fscanf(fd, " %c", op) == 1) begin
            ops++;
            case (op)
                "#": code = $fgets(skip_line, fd);
                "F": begin
                    code = $fscanf(fd, "%h %h %h", vpn, ppn, perm);
                    assert (code == 3) else begin
                        errors++;
                        $display("Incomplete fill operation in the pattern file");
                    end
                    step_cycle();
                    fill_valid = 1'b1;
                    fill.vpn   = vpn;
                    fill.ppn   = ppn;
                    fill.perm  = perm;
                end
                "L": begin
                    code = $fscanf(fd, "%h %h %h %h", vpn, hit, ppn, perm);
                    assert (code == 4) else begin
                        errors++;
                        $display("Incomplete lookup operation in the pattern file");
                    end
                    step_cycle();
                    req_valid     = 1'b1;
                    req.vpn       = vpn;
                    next.due      = cycle + 2;
                    next.rsp.hit  = hit;
                    next.rsp.ppn  = ppn;
                    next.rsp.perm = perm;
                    exp_q.push_back(next);
                end
                "I": begin
                    step_cycle();
                    inv_all = 1'b1;
                end
                "W": begin
                    code = $fscanf(fd, "%d", count);
                    assert (code == 1) else begin
                        errors++;
                        $display("Missing idle cycle count in the pattern file");
                    end
                    repeat (count) step_cycle();
                end
                default: begin
                    errors++;
                    $display("Unknown operation '%c' in the pattern file", op);
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        step_cycle();

        // Let outstanding lookups come back
        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < DRAIN_LIMIT) begin
            step_cycle();
            wait_cycles++;
        end
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("Timed out with %0d responses still outstanding", exp_q.size());
        end
        step_cycle();

        $display("Lookups checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== verilog/devtlb_gen_ram.sv ====
// Generic flop array with one write port, an optional registered read port and
// two optional full-payload CAM compare ports
// Writes land in storage one edge after the write inputs are sampled
// CAM hits are raw matches against storage, without any notion of entry valid
// depth must be a power of two

`timescale 1ns/1ps

`include "devtlb_settings.svh"

module devtlb_gen_ram #(
    parameter int  depth  = `DEVTLB_ENTRIES,
    parameter type T      = logic [7:0],
    parameter bit  cam_en = 1'b0,
    parameter bit  rd_en  = 1'b1
) (
    input  logic                     gramclk,
    input  logic                     rst,

    input  logic                     wr_en,
    input  logic [$clog2(depth)-1:0] wr_addr,
    input  T                         wr_data,

    input  logic [$clog2(depth)-1:0] rd_addr,
    output T                         rd_data,

    input  T                         cam_key_lookup,
    input  T                         cam_key_fill,
    output logic [depth-1:0]         cam_hit_lookup,
    output logic [depth-1:0]         cam_hit_fill
);

    localparam int ADDR_W = $clog2(depth);

    // Input flop stage
    logic              wr_en_q;
    logic [ADDR_W-1:0] wr_addr_q;
    T                  wr_data_q;

    T                  mem [depth];

    // ------------------------------------------------------------------------
    // Write path
    // ------------------------------------------------------------------------

    always_ff @(posedge gramclk) begin
        if (rst) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= wr_en;
        end
    end

    // Address and data only matter while wr_en_q is set
    always_ff @(posedge gramclk) begin
        wr_addr_q <= wr_addr;
        wr_data_q <= wr_data;
    end

    always_ff @(posedge gramclk) begin
        if (wr_en_q) begin
            mem[wr_addr_q] <= wr_data_q;
        end
    end

    // ------------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------------

    generate
        if (rd_en) begin : g_rd
            always_ff @(posedge gramclk) begin
                rd_data <= mem[rd_addr];
            end
        end else begin : g_no_rd
            assign rd_data = '0;
        end
    endgenerate

    // ------------------------------------------------------------------------
    // CAM ports
    // ------------------------------------------------------------------------

    generate
        if (cam_en) begin : g_cam
            for (genvar i = 0; i < depth; i++) begin : g_entry
                assign cam_hit_lookup[i] = (mem[i] == cam_key_lookup);
                assign cam_hit_fill[i]   = (mem[i] == cam_key_fill);
            end
        end else begin : g_no_cam
            assign cam_hit_lookup = '0;
            assign cam_hit_fill   = '0;
        end
    endgenerate

    // The write enable feeds the storage clock enable, so X here corrupts state
    a_wr_en_known: assert property (
        @(posedge gramclk) disable iff (rst) !$isunknown(wr_en)
    ) else $error("devtlb_gen_ram: wr_en is unknown");

endmodule

// ==== verilog/devtlb_lookup.sv ====
// TLB control around a tag CAM array and a data array
// Lookup latency is exactly two cycles, one request per cycle, no stall
// A fill becomes visible to lookups sampled two edges after it
// inv_all wins over a fill sampled one edge earlier but not over one sampled
// at the same edge

`timescale 1ns/1ps

`include "devtlb_settings.svh"

module devtlb_lookup (
    input  logic                          gramclk,
    input  logic                          rst,

    input  logic                          req_valid,
    input  devtlb_pkg::devtlb_req_t       req,
    input  logic                          fill_valid,
    input  devtlb_pkg::devtlb_fill_t      fill,
    input  logic                          inv_all,

    output logic                          rsp_valid,
    output devtlb_pkg::devtlb_rsp_t       rsp,

    output logic                          tag_wr_en,
    output logic [`DEVTLB_IDX_W-1:0]      tag_wr_addr,
    output devtlb_pkg::devtlb_tag_t       tag_wr_data,

    output logic                          data_wr_en,
    output logic [`DEVTLB_IDX_W-1:0]      data_wr_addr,
    output devtlb_pkg::devtlb_data_t      data_wr_data,
    output logic [`DEVTLB_IDX_W-1:0]      data_rd_addr,

    output devtlb_pkg::devtlb_tag_t       cam_key_lookup,
    output devtlb_pkg::devtlb_tag_t       cam_key_fill,
    input  logic [`DEVTLB_ENTRIES-1:0]    cam_hit_lookup,
    input  logic [`DEVTLB_ENTRIES-1:0]    cam_hit_fill,
    input  devtlb_pkg::devtlb_data_t      data_rd_data
);

    import devtlb_pkg::*;

    localparam int DEPTH = `DEVTLB_ENTRIES;
    localparam int IDX_W = `DEVTLB_IDX_W;

    logic [DEPTH-1:0] valid_q;
    logic [IDX_W-1:0] rr_ptr;

    // Fill that has reached the array input flops but not yet storage
    logic             pend_valid;
    logic [IDX_W-1:0] pend_idx;
    devtlb_tag_t      pend_vpn;
    logic [DEPTH-1:0] pend_mask;

    logic [DEPTH-1:0] valid_eff;
    logic [DEPTH-1:0] fill_hit;
    logic [IDX_W-1:0] victim_idx;
    logic             rr_adv;

    // Lookup pipeline
    logic             s1_valid;
    devtlb_tag_t      s1_vpn;
    logic [DEPTH-1:0] hit_lookup;
    logic [IDX_W-1:0] lookup_idx;
    logic             s2_hit;

    // ------------------------------------------------------------------------
    // Victim choice
    // ------------------------------------------------------------------------

    assign cam_key_fill = fill.vpn;

    always_comb begin
        pend_mask = '0;
        if (pend_valid) begin
            pend_mask[pend_idx] = 1'b1;
        end
        valid_eff = valid_q | pend_mask;

        // Storage at pend_idx is stale, so the pending page stands in for it
        fill_hit = cam_hit_fill & valid_q & ~pend_mask;
        if (pend_valid && (pend_vpn == fill.vpn)) begin
            fill_hit = fill_hit | pend_mask;
        end

        // Same page, else lowest invalid, else round-robin
        victim_idx = rr_ptr;
        rr_adv     = 1'b1;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!valid_eff[i]) begin
                victim_idx = IDX_W'(i);
                rr_adv     = 1'b0;
            end
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (fill_hit[i]) begin
                victim_idx = IDX_W'(i);
                rr_adv     = 1'b0;
            end
        end
    end

    assign tag_wr_en         = fill_valid;
    assign tag_wr_addr       = victim_idx;
    assign tag_wr_data       = fill.vpn;
    assign data_wr_en        = fill_valid;
    assign data_wr_addr      = victim_idx;
    assign data_wr_data.ppn  = fill.ppn;
    assign data_wr_data.perm = fill.perm;

    always_ff @(posedge gramclk) begin
        if (rst) begin
            pend_valid <= 1'b0;
            rr_ptr     <= '0;
            valid_q    <= '0;
        end else begin
            pend_valid <= fill_valid;
            if (fill_valid && rr_adv) begin
                rr_ptr <= rr_ptr + 1'b1;
            end
            if (inv_all) begin
                valid_q <= '0;
            end else begin
                valid_q <= valid_q | pend_mask;
            end
        end
    end

    always_ff @(posedge gramclk) begin
        pend_idx <= victim_idx;
        pend_vpn <= fill.vpn;
    end

    // ------------------------------------------------------------------------
    // Lookup pipeline
    // ------------------------------------------------------------------------

    assign cam_key_lookup = s1_vpn;
    assign hit_lookup     = cam_hit_lookup & valid_q;

    always_comb begin
        lookup_idx = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (hit_lookup[i]) begin
                lookup_idx = IDX_W'(i);
            end
        end
    end

    assign data_rd_addr = lookup_idx;

    always_ff @(posedge gramclk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            rsp_valid <= 1'b0;
            s2_hit    <= 1'b0;
        end else begin
            s1_valid  <= req_valid;
            rsp_valid <= s1_valid;
            s2_hit    <= s1_valid && (|hit_lookup);
        end
    end

    always_ff @(posedge gramclk) begin
        s1_vpn <= req.vpn;
    end

    // Registered data array output, forced to zero on a miss
    assign rsp.hit  = s2_hit;
    assign rsp.ppn  = s2_hit ? data_rd_data.ppn : '0;
    assign rsp.perm = s2_hit ? data_rd_data.perm : '0;

    // A duplicate page in the tag array would mean victim choice went wrong
    a_lookup_hit_onehot: assert property (
        @(posedge gramclk) disable iff (rst) s1_valid |-> $onehot0(hit_lookup)
    ) else $error("devtlb_lookup: multiple lookup hits");

    a_fill_hit_onehot: assert property (
        @(posedge gramclk) disable iff (rst) fill_valid |-> $onehot0(fill_hit)
    ) else $error("devtlb_lookup: multiple fill hits");

endmodule

// ==== verilog/devtlb_pkg.sv ====
// Shared types of the device TLB
// All widths come from the settings header, which must be on the include path

`include "devtlb_settings.svh"

package devtlb_pkg;

    // Tag array payload, searched by the CAM
    typedef logic [`DEVTLB_VPN_W-1:0] devtlb_tag_t;

    // Data array payload, read by index
    typedef struct packed {
        logic [`DEVTLB_PPN_W-1:0]  ppn;
        logic [`DEVTLB_PERM_W-1:0] perm;
    } devtlb_data_t;

    typedef struct packed {
        logic [`DEVTLB_VPN_W-1:0] vpn;
    } devtlb_req_t;

    typedef struct packed {
        logic [`DEVTLB_VPN_W-1:0]  vpn;
        logic [`DEVTLB_PPN_W-1:0]  ppn;
        logic [`DEVTLB_PERM_W-1:0] perm;
    } devtlb_fill_t;

    // ppn and perm read as zero on a miss
    typedef struct packed {
        logic                      hit;
        logic [`DEVTLB_PPN_W-1:0]  ppn;
        logic [`DEVTLB_PERM_W-1:0] perm;
    } devtlb_rsp_t;

endpackage

// ==== verilog/devtlb_settings.svh ====
// Sizing of the device TLB arrays and fields
// DEVTLB_ENTRIES must equal 2**DEVTLB_IDX_W so the replacement pointer wraps cleanly
// Changing the page widths changes every struct in the package

`ifndef DEVTLB_SETTINGS_SVH
`define DEVTLB_SETTINGS_SVH

// Array depth and index
`define DEVTLB_ENTRIES  16
`define DEVTLB_IDX_W    4

// Page number widths
`define DEVTLB_VPN_W    20
`define DEVTLB_PPN_W    20

// Permission bits, read in the upper bit and write in the lower
`define DEVTLB_PERM_W   2

`endif

// ==== verilog/devtlb_top.sv ====
// Device TLB top level, a tag CAM array and a data array under one controller
// No back-pressure, responses come exactly two cycles after each request

`timescale 1ns/1ps

`include "devtlb_settings.svh"

module devtlb_top (
    input  logic                     gramclk,
    input  logic                     rst,
    input  logic                     req_valid,
    input  devtlb_pkg::devtlb_req_t  req,
    input  logic                     fill_valid,
    input  devtlb_pkg::devtlb_fill_t fill,
    input  logic                     inv_all,
    output logic                     rsp_valid,
    output devtlb_pkg::devtlb_rsp_t  rsp
);

    import devtlb_pkg::*;

    logic                          tag_wr_en;
    logic [`DEVTLB_IDX_W-1:0]      tag_wr_addr;
    devtlb_tag_t                   tag_wr_data;
    logic                          data_wr_en;
    logic [`DEVTLB_IDX_W-1:0]      data_wr_addr;
    devtlb_data_t                  data_wr_data;
    logic [`DEVTLB_IDX_W-1:0]      data_rd_addr;
    devtlb_data_t                  data_rd_data;
    devtlb_tag_t                   cam_key_lookup;
    devtlb_tag_t                   cam_key_fill;
    logic [`DEVTLB_ENTRIES-1:0]    cam_hit_lookup;
    logic [`DEVTLB_ENTRIES-1:0]    cam_hit_fill;

    devtlb_lookup i_devtlb_lookup (
        .gramclk        (gramclk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req            (req),
        .fill_valid     (fill_valid),
        .fill           (fill),
        .inv_all        (inv_all),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .tag_wr_en      (tag_wr_en),
        .tag_wr_addr    (tag_wr_addr),
        .tag_wr_data    (tag_wr_data),
        .data_wr_en     (data_wr_en),
        .data_wr_addr   (data_wr_addr),
        .data_wr_data   (data_wr_data),
        .data_rd_addr   (data_rd_addr),
        .cam_key_lookup (cam_key_lookup),
        .cam_key_fill   (cam_key_fill),
        .cam_hit_lookup (cam_hit_lookup),
        .cam_hit_fill   (cam_hit_fill),
        .data_rd_data   (data_rd_data)
    );

    // Tag array, searched only
    devtlb_gen_ram #(
        .depth  (`DEVTLB_ENTRIES),
        .T      (devtlb_tag_t),
        .cam_en (1'b1),
        .rd_en  (1'b0)
    ) i_tag_ram (
        .gramclk        (gramclk),
        .rst            (rst),
        .wr_en          (tag_wr_en),
        .wr_addr        (tag_wr_addr),
        .wr_data        (tag_wr_data),
        .rd_addr        (),
        .rd_data        (),
        .cam_key_lookup (cam_key_lookup),
        .cam_key_fill   (cam_key_fill),
        .cam_hit_lookup (cam_hit_lookup),
        .cam_hit_fill   (cam_hit_fill)
    );

    // Data array, read by the encoded hit index
    devtlb_gen_ram #(
        .depth  (`DEVTLB_ENTRIES),
        .T      (devtlb_data_t),
        .cam_en (1'b0),
        .rd_en  (1'b1)
    ) i_data_ram (
        .gramclk        (gramclk),
        .rst            (rst),
        .wr_en          (data_wr_en),
        .wr_addr        (data_wr_addr),
        .wr_data        (data_wr_data),
        .rd_addr        (data_rd_addr),
        .rd_data        (data_rd_data),
        .cam_key_lookup (),
        .cam_key_fill   (),
        .cam_hit_lookup (),
        .cam_hit_fill   ()
    );

endmodule
